// ==== hw/rate_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// rate generator types and pipeline constants
////////////////////////////////////////////////////////////

package rate_pkg;

    // one width for numerator, step and the phase accumulator.
    // the step is added every active cycle, and a wrap subtracts the
    // numerator, so the strobe rate is step/freq_num of sys_clk
    typedef logic [31:0] rate_num_t;

    // hold-off after the config is captured
    // the accumulator must not wrap before this has passed
    localparam int RDY_DLY = 7;     // cycles, config capture to first wrap

    // strobe output pipeline
    localparam int OUT_DLY = 8;     // cycles, wrap decision to strobe

endpackage

`default_nettype wire

// ==== hw/stat_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// window meter types and constants
////////////////////////////////////////////////////////////

package stat_pkg;

    typedef logic [15:0] win_cnt_t;     // strobe counts and gap spacing

    localparam int WINDOW_CYCLES = 4096;    // sys_clk cycles per window

    // meter waits for a byte strobe before the first window opens
    typedef enum logic [0:0] {
        WAIT_FIRST,
        MEASURE
    } win_state_t;

endpackage

`default_nettype wire

// ==== hw/frac_strobe_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module frac_strobe_gen (
    input  wire                      sys_clk,
    input  wire                      glb_rst_n,
    input  wire rate_pkg::rate_num_t freq_num,     // rate denominator
    input  wire rate_pkg::rate_num_t step,         // phase added per cycle
    output logic                     strobe,
    output logic                     strobe_half
);

    import rate_pkg::*;

    rate_num_t          freq_reg;
    rate_num_t          step_reg;
    logic               cfg_rdy;
    logic [RDY_DLY-1:0] rdy_sr;
    logic               rdy;

    rate_num_t          phase;
    rate_num_t          phase_sum;
    logic               wrap;

    logic [OUT_DLY-1:0] wrap_sr;
    logic               half_tgl;

    ////////////////////////////////////////////////////////////
    // config capture and ready hold-off
    ////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (!glb_rst_n) begin
            freq_reg <= '0;
            step_reg <= '0;
            cfg_rdy  <= 1'b0;
        end else begin
            freq_reg <= freq_num;   // a new rate lands on the next accumulate
            step_reg <= step;
            cfg_rdy  <= 1'b1;       // 1 cycle after reset release
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!glb_rst_n) begin
            rdy_sr <= '0;
        end else begin
            rdy_sr <= {rdy_sr[RDY_DLY-2:0], cfg_rdy};
        end
    end

    assign rdy = rdy_sr[RDY_DLY-1];    // RDY_DLY cycles behind cfg_rdy

    ////////////////////////////////////////////////////////////
    // phase accumulator
    ////////////////////////////////////////////////////////////

    assign phase_sum = phase + step_reg;
    assign wrap      = rdy && (phase_sum >= freq_reg);

    // the phase starts from zero when the hold-off ends, so it sits
    // below freq_num from the first accumulate on
    always_ff @(posedge sys_clk) begin
        if (!glb_rst_n) begin
            phase <= '0;
        end else if (wrap) begin
            phase <= phase_sum - freq_reg;  // keep the remainder
        end else if (rdy) begin
            phase <= phase_sum;
        end
    end

    ////////////////////////////////////////////////////////////
    // output delay and half-rate gate
    ////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (!glb_rst_n) begin
            wrap_sr <= '0;
        end else begin
            wrap_sr <= {wrap_sr[OUT_DLY-2:0], wrap};
        end
    end

    assign strobe = wrap_sr[OUT_DLY-1];    // OUT_DLY cycles after the wrap

    always_ff @(posedge sys_clk) begin
        if (!glb_rst_n) begin
            half_tgl <= 1'b0;
        end else if (strobe) begin
            half_tgl <= ~half_tgl;          // flips after every strobe
        end
    end

    // odd strobes only, counting from the first one after reset
    assign strobe_half = strobe && !half_tgl;

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // up to half of sys_clk every strobe is a single-cycle pulse
    assert property (@(posedge sys_clk) disable iff (!glb_rst_n)
        (strobe && (step_reg <= (freq_reg >> 1))) |=> !strobe)
        else $error("frac_strobe_gen: back-to-back strobe at sub-half rate");

    // one subtract per wrap is enough while step does not pass freq_num
    assert property (@(posedge sys_clk) disable iff (!glb_rst_n)
        (rdy && (phase < freq_reg) && (step_reg <= freq_reg))
        |=> (phase < $past(freq_reg)))
        else $error("frac_strobe_gen: phase escaped the freq_num range");

endmodule

`default_nettype wire

// ==== hw/strobe_window_meter.sv ====
`timescale 1ns/1ps
`default_nettype none

module strobe_window_meter (
    input  wire                sys_clk,
    input  wire                glb_rst_n,
    input  wire                samp_strobe,
    input  wire                byte_strobe,
    output logic               win_done,       // one cycle, results valid
    output stat_pkg::win_cnt_t samp_count,
    output stat_pkg::win_cnt_t byte_count,
    output stat_pkg::win_cnt_t spacing_min,
    output stat_pkg::win_cnt_t spacing_max
);

    import stat_pkg::*;

    win_state_t state;
    win_cnt_t   cyc_cnt;
    logic       win_end;

    win_cnt_t   samp_run;
    win_cnt_t   byte_run;
    win_cnt_t   min_run;
    win_cnt_t   max_run;
    logic       skip_gap;

    win_cnt_t   gap_cnt;
    win_cnt_t   gap_val;

    win_cnt_t   samp_nxt;
    win_cnt_t   byte_nxt;
    win_cnt_t   min_nxt;
    win_cnt_t   max_nxt;

    ////////////////////////////////////////////////////////////
    // state and window timing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (!glb_rst_n) begin
            state <= WAIT_FIRST;
        end else begin
            case (state)
                WAIT_FIRST: if (byte_strobe) state <= MEASURE;
                MEASURE:    state <= MEASURE;   // runs until reset
                default:    state <= WAIT_FIRST;
            endcase
        end
    end

    // last cycle of the window, its strobes still count
    assign win_end = (state == MEASURE) && (cyc_cnt == win_cnt_t'(WINDOW_CYCLES - 1));

    ////////////////////////////////////////////////////////////
    // gap between byte strobes
    ////////////////////////////////////////////////////////////

    // a sample strobe on the same cycle as a byte strobe closes the gap
    assign gap_val = gap_cnt + win_cnt_t'(samp_strobe);

    always_ff @(posedge sys_clk) begin
        if (!glb_rst_n) begin
            gap_cnt <= '0;
        end else if (byte_strobe) begin
            gap_cnt <= '0;
        end else if (samp_strobe) begin
            gap_cnt <= gap_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // running counts
    ////////////////////////////////////////////////////////////

    always_comb begin
        samp_nxt = samp_run + win_cnt_t'(samp_strobe);
        byte_nxt = byte_run + win_cnt_t'(byte_strobe);
        min_nxt  = min_run;
        max_nxt  = max_run;
        if (byte_strobe && !skip_gap) begin
            if (gap_val < min_run) begin
                min_nxt = gap_val;
            end
            if (gap_val > max_run) begin
                max_nxt = gap_val;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!glb_rst_n) begin
            cyc_cnt  <= '0;
            samp_run <= '0;
            byte_run <= '0;
            min_run  <= '1;
            max_run  <= '0;
            skip_gap <= 1'b1;
        end else if (state == MEASURE) begin
            if (win_end) begin
                cyc_cnt  <= '0;
                samp_run <= '0;
                byte_run <= '0;
                min_run  <= '1;             // any real gap is smaller
                max_run  <= '0;
                skip_gap <= 1'b1;           // first gap may be partial
            end else begin
                cyc_cnt  <= cyc_cnt + 1'b1;
                samp_run <= samp_nxt;
                byte_run <= byte_nxt;
                min_run  <= min_nxt;
                max_run  <= max_nxt;
                if (byte_strobe) begin
                    skip_gap <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // window results
    ////////////////////////////////////////////////////////////

    // results and win_done appear together, WINDOW_CYCLES after the window opened
    always_ff @(posedge sys_clk) begin
        if (!glb_rst_n) begin
            win_done    <= 1'b0;
            samp_count  <= '0;
            byte_count  <= '0;
            spacing_min <= '0;
            spacing_max <= '0;
        end else begin
            win_done <= win_end;
            if (win_end) begin
                samp_count  <= samp_nxt;    // held until next window
                byte_count  <= byte_nxt;
                spacing_min <= min_nxt;
                spacing_max <= max_nxt;
            end
        end
    end

    // at most one strobe of each kind per cycle of the window
    assert property (@(posedge sys_clk) disable iff (!glb_rst_n)
        win_done |-> ((samp_count <= win_cnt_t'(WINDOW_CYCLES))
                      && (byte_count <= win_cnt_t'(WINDOW_CYCLES))))
        else $error("strobe_window_meter: window count above WINDOW_CYCLES");

endmodule

`default_nettype wire

// ==== hw/ts_rate_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ts_rate_top (
    input  wire                      sys_clk,
    input  wire                      glb_rst_n,

    // sample strobe rate
    input  wire rate_pkg::rate_num_t samp_freq_num,
    input  wire rate_pkg::rate_num_t samp_step,

    // byte strobe rate
    input  wire rate_pkg::rate_num_t byte_freq_num,
    input  wire rate_pkg::rate_num_t byte_step,

    output logic                     samp_strobe,
    output logic                     samp_strobe_half,
    output logic                     byte_strobe,

    // window results
    output logic                     win_done,
    output stat_pkg::win_cnt_t       samp_count,
    output stat_pkg::win_cnt_t       byte_count,
    output stat_pkg::win_cnt_t       spacing_min,
    output stat_pkg::win_cnt_t       spacing_max
);

    ////////////////////////////////////////////////////////////
    // strobe generators
    ////////////////////////////////////////////////////////////

    frac_strobe_gen samp_gen_inst (
        .sys_clk     (sys_clk),
        .glb_rst_n   (glb_rst_n),
        .freq_num    (samp_freq_num),
        .step        (samp_step),
        .strobe      (samp_strobe),
        .strobe_half (samp_strobe_half)
    );

    frac_strobe_gen byte_gen_inst (
        .sys_clk     (sys_clk),
        .glb_rst_n   (glb_rst_n),
        .freq_num    (byte_freq_num),
        .step        (byte_step),
        .strobe      (byte_strobe),
        .strobe_half ()                 // half-rate byte strobe not needed
    );

    ////////////////////////////////////////////////////////////
    // rate measurement
    ////////////////////////////////////////////////////////////

    strobe_window_meter window_meter_inst (
        .sys_clk     (sys_clk),
        .glb_rst_n   (glb_rst_n),
        .samp_strobe (samp_strobe),
        .byte_strobe (byte_strobe),
        .win_done    (win_done),
        .samp_count  (samp_count),
        .byte_count  (byte_count),
        .spacing_min (spacing_min),
        .spacing_max (spacing_max)
    );

endmodule

`default_nettype wire

// ==== include/tb_cases.svh ====
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

////////////////////////////////////////////////////////////
// rate pairs applied by the testbench, one case per row
////////////////////////////////////////////////////////////

// expected counts and spacing follow from these by the rate rule
typedef struct packed {
    rate_pkg::rate_num_t samp_freq_num;
    rate_pkg::rate_num_t samp_step;
    rate_pkg::rate_num_t byte_freq_num;
    rate_pkg::rate_num_t byte_step;
} tb_case_t;

localparam int TB_NUM_CASES = 6;

// samp_freq_num, samp_step, byte_freq_num, byte_step
localparam tb_case_t TB_CASES [TB_NUM_CASES] = '{
    // ratio 4, whole number
    '{32'd100,        32'd20,        32'd100,        32'd5},
    // ratio 30/7, gaps of 4 and 5
    '{32'd1000,       32'd300,       32'd1000,       32'd70},
    // sample strobe every second cycle
    '{32'd10,         32'd5,         32'd10,         32'd1},
    // large numerators, ratio 8
    '{32'd27_000_000, 32'd1_000_000, 32'd27_000_000, 32'd125_000},
    // odd denominator, ratio 3
    '{32'd7,          32'd3,         32'd7,          32'd1},
    // both strobes every cycle
    '{32'd50,         32'd50,        32'd64,         32'd64}
};

`endif

// ==== tests/tb_ts_rate.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ts_rate;

    import rate_pkg::*;
    import stat_pkg::*;

    `include "tb_cases.svh"

    localparam int CLK_PERIOD_NS = 4;
    localparam int RST_CYCLES    = 3;
    localparam int HOLD_CYCLES   = 9;      // well inside 1 + RDY_DLY + OUT_DLY
    localparam int CASE_LIMIT    = 3 * WINDOW_CYCLES;   // cycles allowed per case
    localparam int WATCHDOG_NS   = TB_NUM_CASES * 3 * WINDOW_CYCLES * CLK_PERIOD_NS
                                   + WINDOW_CYCLES * CLK_PERIOD_NS;

    logic      sys_clk;
    logic      glb_rst_n;
    rate_num_t samp_freq_num;
    rate_num_t samp_step;
    rate_num_t byte_freq_num;
    rate_num_t byte_step;

    logic      samp_strobe;
    logic      samp_strobe_half;
    logic      byte_strobe;
    logic      win_done;
    win_cnt_t  samp_count;
    win_cnt_t  byte_count;
    win_cnt_t  spacing_min;
    win_cnt_t  spacing_max;

    int        err_cnt;
    int        fail_cases;

    ts_rate_top ts_rate_top_inst (
        .sys_clk          (sys_clk),
        .glb_rst_n        (glb_rst_n),
        .samp_freq_num    (samp_freq_num),
        .samp_step        (samp_step),
        .byte_freq_num    (byte_freq_num),
        .byte_step        (byte_step),
        .samp_strobe      (samp_strobe),
        .samp_strobe_half (samp_strobe_half),
        .byte_strobe      (byte_strobe),
        .win_done         (win_done),
        .samp_count       (samp_count),
        .byte_count       (byte_count),
        .spacing_min      (spacing_min),
        .spacing_max      (spacing_max)
    );

    always #(CLK_PERIOD_NS / 2) sys_clk = ~sys_clk;

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic check_range(input string name, input longint lo, input longint hi,
                               input longint act);
        assert ((act >= lo) && (act <= hi)) else begin
            $display("ERR %0t %s expected %0d..%0d actual %0d", $time, name, lo, hi, act);
            err_cnt++;
        end
    endtask

    // window count of one strobe, exact at full rate
    task automatic check_count(input string name, input rate_num_t step,
                               input rate_num_t freq, input longint act);
        longint expv;
        longint tol;
        expv = longint'(WINDOW_CYCLES) * longint'(step) / longint'(freq);
        tol  = (step == freq) ? 64'd0 : 64'd1;
        check_range(name, expv - tol, expv + tol, act);
    endtask

    task automatic check_quiet(input int idx);
        assert (!samp_strobe && !samp_strobe_half && !byte_strobe && !win_done) else begin
            $display("case %0d: strobe or win_done during reset hold-off at %0t", idx, $time);
            err_cnt++;
        end
        check_range("samp_count", 64'd0, 64'd0, longint'(samp_count));
        check_range("byte_count", 64'd0, 64'd0, longint'(byte_count));
        check_range("spacing_min", 64'd0, 64'd0, longint'(spacing_min));
        check_range("spacing_max", 64'd0, 64'd0, longint'(spacing_max));
    endtask

    // pulse shape plus the full and half rate patterns
    task automatic check_strobe(input string name, input logic cur, input logic prev,
                                input logic seen, input rate_num_t freq, input rate_num_t step);
        longint f;
        longint s;
        f = longint'(freq);
        s = longint'(step);
        if (2 * s <= f) begin
            assert (!(cur && prev)) else begin
                $display("%s high on two cycles in a row at %0t", name, $time);
                err_cnt++;
            end
        end
        if (seen && (s == f)) begin
            assert (cur) else begin
                $display("%s missed a cycle at full rate at %0t", name, $time);
                err_cnt++;
            end
        end
        if (seen && (2 * s == f)) begin
            assert (cur != prev) else begin
                $display("%s not alternating at half rate at %0t", name, $time);
                err_cnt++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one table row
    ////////////////////////////////////////////////////////////

    task automatic run_case(input int idx);
        tb_case_t tc;
        int       i;
        int       gap;
        int       cyc;
        int       done_seen;
        int       start_err;
        int       full_cnt;
        int       half_cnt;
        logic     prev_samp;
        logic     prev_byte;
        logic     prev_done;
        logic     samp_seen;
        logic     byte_seen;
        longint   num;
        longint   den;

        tc        = TB_CASES[idx];
        start_err = err_cnt;
        gap       = int'($urandom % 32'd8);
        cyc       = 0;
        done_seen = 0;
        full_cnt  = 0;
        half_cnt  = 0;
        prev_samp = 1'b0;
        prev_byte = 1'b0;
        prev_done = 1'b0;
        samp_seen = 1'b0;
        byte_seen = 1'b0;

        repeat (gap) @(posedge sys_clk);
        @(posedge sys_clk);
        #1;
        samp_freq_num = tc.samp_freq_num;
        samp_step     = tc.samp_step;
        byte_freq_num = tc.byte_freq_num;
        byte_step     = tc.byte_step;
        glb_rst_n     = 1'b0;

        for (i = 0; i < RST_CYCLES + HOLD_CYCLES; i++) begin
            @(posedge sys_clk);
            if (i == RST_CYCLES - 1) begin
                #1;
                glb_rst_n = 1'b1;                   // release after the 3rd edge
            end
            @(negedge sys_clk);
            check_quiet(idx);
        end

        while ((done_seen < 2) && (cyc < CASE_LIMIT)) begin
            @(negedge sys_clk);
            cyc++;
            if (win_done) begin
                done_seen++;
            end
            if (done_seen == 1) begin               // second window only
                if (samp_strobe) full_cnt++;
                if (samp_strobe_half) half_cnt++;
            end
            check_strobe("samp_strobe", samp_strobe, prev_samp, samp_seen,
                         tc.samp_freq_num, tc.samp_step);
            check_strobe("byte_strobe", byte_strobe, prev_byte, byte_seen,
                         tc.byte_freq_num, tc.byte_step);
            assert (!(win_done && prev_done)) else begin
                $display("win_done high on two cycles in a row at %0t", $time);
                err_cnt++;
            end
            samp_seen = samp_seen || samp_strobe;
            byte_seen = byte_seen || byte_strobe;
            prev_samp = samp_strobe;
            prev_byte = byte_strobe;
            prev_done = win_done;
        end

        if (done_seen < 2) begin
            $display("case %0d: second win_done missing after %0d cycles", idx, CASE_LIMIT);
            err_cnt++;
        end else begin
            check_count("samp_count", tc.samp_step, tc.samp_freq_num, longint'(samp_count));
            check_count("byte_count", tc.byte_step, tc.byte_freq_num, longint'(byte_count));
            // sample strobes per byte strobe, floor and ceiling
            num = longint'(tc.samp_step) * longint'(tc.byte_freq_num);
            den = longint'(tc.samp_freq_num) * longint'(tc.byte_step);
            check_range("spacing_min", num / den, (num + den - 1) / den, longint'(spacing_min));
            check_range("spacing_max", num / den, (num + den - 1) / den, longint'(spacing_max));
            check_range("samp_strobe_half", longint'(full_cnt / 2 - 1),
                        longint'(full_cnt / 2 + 1), longint'(half_cnt));
        end

        if (err_cnt == start_err) begin
            $display("case %0d passed: samp %0d byte %0d spacing %0d..%0d half %0d/%0d",
                     idx, samp_count, byte_count, spacing_min, spacing_max,
                     half_cnt, full_cnt);
        end else begin
            fail_cases++;
            $display("case %0d failed with %0d errors", idx, err_cnt - start_err);
        end
    endtask

    initial begin
        int idx;
        void'($urandom(32'hf567_f0e7));
        err_cnt       = 0;
        fail_cases    = 0;
        sys_clk       = 1'b0;
        glb_rst_n     = 1'b0;
        samp_freq_num = '0;
        samp_step     = '0;
        byte_freq_num = '0;
        byte_step     = '0;

        for (idx = 0; idx < TB_NUM_CASES; idx++) begin
            run_case(idx);
        end

        $display("%0d cases run, %0d failed, %0d check errors",
                 TB_NUM_CASES, fail_cases, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hw/rate_pkg.sv
hw/stat_pkg.sv
hw/frac_strobe_gen.sv
hw/strobe_window_meter.sv
hw/ts_rate_top.sv
tests/tb_ts_rate.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ts_rate testbench with Verilator
set -u
set -o pipefail

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

rm -f "$LOG"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_ts_rate \
    --Mdir "$BUILD_DIR" \
    -o tb_ts_rate_sim \
    && "./$BUILD_DIR/tb_ts_rate_sim" 2>&1 | tee "$LOG" \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "Test FAILED" "$LOG" && { echo "simulation reported failure"; exit 1; }
grep -q "Test OK" "$LOG" || { echo "pass message missing from $LOG"; exit 1; }

echo "simulation passed"
exit 0
